/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    parameter int XLEN   = 32;
    parameter int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4
    } alu_op_e;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} res_sel_e;

    // major opcodes of the supported subset
    parameter logic [6:0] OP_R   = 7'b0110011;
    parameter logic [6:0] OP_I   = 7'b0010011;
    parameter logic [6:0] OP_LW  = 7'b0000011;
    parameter logic [6:0] OP_SW  = 7'b0100011;
    parameter logic [6:0] OP_BR  = 7'b1100011;
    parameter logic [6:0] OP_JAL = 7'b1101111;

    typedef struct packed {
        logic     reg_write;
        res_sel_e res_sel;
        logic     mem_write;
        logic     branch;
        logic     bne;       // invert equality for bne
        logic     jump;
        logic     alu_src;   // 1 selects imm
        alu_op_e  alu_op;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t pc4;
        word_t instr;
    } fd_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     pc;
        word_t     pc4;
        reg_addr_t rd;
        word_t     imm;
    } de_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        res_sel_e  res_sel;
        logic      mem_write;
        word_t     alu;
        word_t     store_data;
        reg_addr_t rd;
        word_t     pc4;
    } em_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        res_sel_e  res_sel;
        word_t     alu;
        word_t     rdata;
        reg_addr_t rd;
        word_t     pc4;
    } mw_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* hdl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  word_t   a_i,
    input  word_t   b_i,
    input  alu_op_e op_i,
    output word_t   y_o,
    output logic    eq_o    // for beq/bne
);
    logic lt;

    assign lt   = $signed(a_i) < $signed(b_i);
    assign eq_o = (a_i == b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_SLT: y_o = {{(XLEN-1){1'b0}}, lt};
            default: y_o = a_i + b_i;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_data_mem import rv_pkg::*; #(
    parameter int DMEM_WORDS = 256
)(
    input  logic  clk_i,
    input  logic  we_i,
    input  word_t addr_i,
    input  word_t wdata_i,
    output word_t rdata_o
);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    word_t                mem [DMEM_WORDS];
    logic [DMEM_AW-1:0]   idx;

    assign idx = addr_i[DMEM_AW+1:2];  // word index, low bits ignored

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[idx];

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  wb_t       wb_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);
    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through bypass so wb in same cycle is visible
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (wb_i.we && (wb_i.rd == rs1_i)) ? wb_i.data : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (wb_i.we && (wb_i.rd == rs2_i)) ? wb_i.data : regs[rs2_i];

endmodule

`default_nettype wire

/* hdl/rv_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_stage_reg #(
    parameter type payload_t = logic
)(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,   // kills the payload on the next edge
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;      // valid drops with the rest
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  fd_t       fd_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output de_t       de_o
);
    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    ctrl_t      ctrl;
    imm_sel_e   imm_sel;
    logic       arith;   // R or I type with alu op from funct fields
    word_t      imm;

    assign instr  = fd_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign rs1_o = instr[19:15];
    assign rs2_o = instr[24:20];

    // main decoder
    always_comb begin
        ctrl    = '0;
        imm_sel = IMM_I;
        arith   = 1'b0;
        case (opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
                arith          = 1'b1;
            end
            OP_I: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                arith          = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_write = 1'b1;
                ctrl.res_sel   = RES_MEM;
                ctrl.alu_src   = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm_sel        = IMM_S;
            end
            OP_BR: begin
                ctrl.branch = 1'b1;
                ctrl.bne    = funct3[0];  // 001 is bne
                imm_sel     = IMM_B;
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.res_sel   = RES_PC4;
                ctrl.jump      = 1'b1;
                imm_sel        = IMM_J;
            end
            default: ;
        endcase

        // alu decoder
        ctrl.alu_op = ALU_ADD;            // address calc for lw/sw
        if (ctrl.branch) begin
            ctrl.alu_op = ALU_SUB;
        end else if (arith) begin
            case (funct3)
                3'b000:  ctrl.alu_op = (instr[5] && instr[30]) ? ALU_SUB : ALU_ADD;
                3'b010:  ctrl.alu_op = ALU_SLT;
                3'b110:  ctrl.alu_op = ALU_OR;
                3'b111:  ctrl.alu_op = ALU_AND;
                default: ctrl.alu_op = ALU_ADD;
            endcase
        end
    end

    // immediate extender
    always_comb begin
        case (imm_sel)
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_J:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        de_o.valid   = fd_i.valid;
        de_o.ctrl    = ctrl;
        de_o.rs1_val = rs1_data_i;
        de_o.rs2_val = rs2_data_i;
        de_o.pc      = fd_i.pc;
        de_o.pc4     = fd_i.pc4;
        de_o.rd      = ctrl.reg_write ? instr[11:7] : '0;  // no stray rd from sw/branch fields
        de_o.imm     = imm;
    end

endmodule

`default_nettype wire

/* hdl/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
    parameter int IMEM_WORDS = 256
)(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  pc_src_i,
    input  word_t pc_target_i,
    input  logic  imem_we_i,
    input  word_t imem_addr_i,   // byte address
    input  word_t imem_data_i,
    output fd_t   fd_o
);
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam word_t NOP  = 32'h0000_0013; // addi x0, x0, 0

    word_t imem [IMEM_WORDS];

    word_t pc;
    word_t pc4;
    word_t next_pc;
    word_t instr;

    assign pc4     = pc + 32'd4;
    assign next_pc = pc_src_i ? pc_target_i : pc4;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    // program load, only while core held in reset
    always_ff @(posedge clk_i) begin
        if (imem_we_i && !rst_n_i && (imem_addr_i[XLEN-1:2] < IMEM_WORDS)) begin
            imem[imem_addr_i[IMEM_AW+1:2]] <= imem_data_i;
        end
    end

    assign instr = (pc[XLEN-1:2] < IMEM_WORDS) ? imem[pc[IMEM_AW+1:2]] : NOP;

    always_comb begin
        fd_o.valid = 1'b1;
        fd_o.pc    = pc;
        fd_o.pc4   = pc4;
        fd_o.instr = instr;
    end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
)(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  imem_we_i,
    input  word_t imem_addr_i,
    input  word_t imem_data_i,
    output wb_t   wb_o
);
    fd_t fetch_fd, dec_fd;
    de_t dec_de, ex_de;
    em_t ex_em, mem_em;
    mw_t mem_mw, wb_mw;
    wb_t wb;

    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data;

    logic  pc_src;
    word_t pc_target;
    word_t alu_b;
    word_t alu_y;
    logic  alu_eq;
    word_t mem_rdata;

    rv_fetch #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .pc_src_i    (pc_src),
        .pc_target_i (pc_target),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .fd_o        (fetch_fd)
    );

    rv_stage_reg #(.payload_t(fd_t)) fd_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (pc_src),
        .d_i     (fetch_fd),
        .q_o     (dec_fd)
    );

    rv_decode u_decode (
        .fd_i       (dec_fd),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .de_o       (dec_de)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_stage_reg #(.payload_t(de_t)) de_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (pc_src),
        .d_i     (dec_de),
        .q_o     (ex_de)
    );

    // execute
    assign alu_b = ex_de.ctrl.alu_src ? ex_de.imm : ex_de.rs2_val;

    rv_alu u_alu (
        .a_i  (ex_de.rs1_val),
        .b_i  (alu_b),
        .op_i (ex_de.ctrl.alu_op),
        .y_o  (alu_y),
        .eq_o (alu_eq)
    );

    assign pc_src = ex_de.valid &
                    (ex_de.ctrl.jump | (ex_de.ctrl.branch & (alu_eq ^ ex_de.ctrl.bne)));
    assign pc_target = ex_de.pc + ex_de.imm;

    always_comb begin
        ex_em.valid      = ex_de.valid;
        ex_em.reg_write  = ex_de.ctrl.reg_write;
        ex_em.res_sel    = ex_de.ctrl.res_sel;
        ex_em.mem_write  = ex_de.ctrl.mem_write;
        ex_em.alu        = alu_y;
        ex_em.store_data = ex_de.rs2_val;
        ex_em.rd         = ex_de.rd;
        ex_em.pc4        = ex_de.pc4;
    end

    rv_stage_reg #(.payload_t(em_t)) em_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (1'b0),
        .d_i     (ex_em),
        .q_o     (mem_em)
    );

    // memory
    rv_data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
        .clk_i   (clk_i),
        .we_i    (mem_em.valid & mem_em.mem_write),
        .addr_i  (mem_em.alu),
        .wdata_i (mem_em.store_data),
        .rdata_o (mem_rdata)
    );

    always_comb begin
        mem_mw.valid     = mem_em.valid;
        mem_mw.reg_write = mem_em.reg_write;
        mem_mw.res_sel   = mem_em.res_sel;
        mem_mw.alu       = mem_em.alu;
        mem_mw.rdata     = mem_rdata;
        mem_mw.rd        = mem_em.rd;
        mem_mw.pc4       = mem_em.pc4;
    end

    rv_stage_reg #(.payload_t(mw_t)) mw_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (1'b0),
        .d_i     (mem_mw),
        .q_o     (wb_mw)
    );

    // writeback select
    always_comb begin
        wb.we = wb_mw.valid & wb_mw.reg_write;
        wb.rd = wb_mw.rd;
        case (wb_mw.res_sel)
            RES_MEM: wb.data = wb_mw.rdata;
            RES_PC4: wb.data = wb_mw.pc4;
            default: wb.data = wb_mw.alu;
        endcase
    end

    assign wb_o = wb;

endmodule

`default_nettype wire

/* verification/rv_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts import rv_pkg::*; (
    input logic clk_i,
    input logic rst_n_i,
    input logic pc_src_i,   // taken branch or jump in execute
    input de_t  ex_de_i,    // de_reg output
    input wb_t  wb_i
);

    // nothing retires while the core is held in reset
    wb_quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_i.we)
        else $error("writeback enable high during reset");

    // the younger instruction behind a redirect never reaches execute
    flush_after_redirect: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pc_src_i |=> !ex_de_i.valid
    ) else $error("de_reg still valid after a taken branch");

    // rd is parked at zero when nothing is written
    rd_zero_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !wb_i.we |-> (wb_i.rd == '0)
    ) else $error("writeback rd nonzero with we low");

endmodule

`default_nettype wire

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam int N_BODY     = 60;       // generated instructions
    localparam int LOOP_IDX   = N_BODY;   // jal x0, 0 right after them
    localparam int WB_TIMEOUT = 2000;     // cycles

    typedef enum logic [3:0] {
        K_ADD, K_SUB, K_AND, K_OR, K_SLT,
        K_ADDI, K_ANDI, K_ORI, K_SLTI,
        K_LW, K_SW, K_BEQ, K_BNE, K_JAL
    } kind_e;

    typedef struct packed {
        kind_e     kind;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
    } op_t;

    logic  clk;
    logic  rst_n;
    logic  imem_we;
    word_t imem_addr;
    word_t imem_data;
    wb_t   wb;

    integer seed;
    op_t    prog [LOOP_IDX+1];
    wb_t    exp_q [$];          // register writes in program order
    int     n_seen = 0;

    rv_core #(
        .IMEM_WORDS (256),
        .DMEM_WORDS (256)
    ) uut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .imem_we_i   (imem_we),
        .imem_addr_i (imem_addr),
        .imem_data_i (imem_data),
        .wb_o        (wb)
    );

    bind rv_core rv_core_asserts u_asserts (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .pc_src_i (pc_src),
        .ex_de_i  (ex_de),
        .wb_i     (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic writes_reg(input kind_e k);
        return !(k == K_SW || k == K_BEQ || k == K_BNE);
    endfunction

    // RV32I encodings straight from the ISA formats
    function automatic word_t encode(input op_t op);
        word_t im;
        im = op.imm;
        case (op.kind)
            K_ADD:   return {7'b0000000, op.rs2, op.rs1, 3'b000, op.rd, 7'b0110011};
            K_SUB:   return {7'b0100000, op.rs2, op.rs1, 3'b000, op.rd, 7'b0110011};
            K_AND:   return {7'b0000000, op.rs2, op.rs1, 3'b111, op.rd, 7'b0110011};
            K_OR:    return {7'b0000000, op.rs2, op.rs1, 3'b110, op.rd, 7'b0110011};
            K_SLT:   return {7'b0000000, op.rs2, op.rs1, 3'b010, op.rd, 7'b0110011};
            K_ADDI:  return {im[11:0], op.rs1, 3'b000, op.rd, 7'b0010011};
            K_ANDI:  return {im[11:0], op.rs1, 3'b111, op.rd, 7'b0010011};
            K_ORI:   return {im[11:0], op.rs1, 3'b110, op.rd, 7'b0010011};
            K_SLTI:  return {im[11:0], op.rs1, 3'b010, op.rd, 7'b0010011};
            K_LW:    return {im[11:0], op.rs1, 3'b010, op.rd, 7'b0000011};
            K_SW:    return {im[11:5], op.rs2, op.rs1, 3'b010, im[4:0], 7'b0100011};
            K_BEQ:   return {im[12], im[10:5], op.rs2, op.rs1, 3'b000, im[4:1], im[11],
                             7'b1100011};
            K_BNE:   return {im[12], im[10:5], op.rs2, op.rs1, 3'b001, im[4:1], im[11],
                             7'b1100011};
            default: return {im[20], im[10:1], im[11], im[19:12], op.rd, 7'b1101111};
        endcase
    endfunction

    // source register that none of the last two instructions writes
    task automatic pick_src(input int avoid_a, input int avoid_b, output reg_addr_t r);
        int v;
        v = {$random(seed)} % 8;
        while (v == avoid_a || v == avoid_b) begin
            v = (v + 1) % 8;
        end
        r = reg_addr_t'(v);
    endtask

    task automatic pick_dst(output reg_addr_t r);
        int v;
        v = {$random(seed)} % 8;   // x0 now and then
        r = reg_addr_t'(v);
    endtask

    task automatic build_program();
        int  d1;
        int  d2;
        int  sel;
        int  skip;
        op_t op;
        d1 = -1;
        d2 = -1;
        // clear the four data slots so loads never see undefined words
        for (int i = 0; i < 4; i++) begin
            op      = '0;
            op.kind = K_SW;
            op.imm  = word_t'(i * 4);
            prog[i] = op;
        end
        for (int i = 4; i < N_BODY; i++) begin
            op      = '0;
            sel     = {$random(seed)} % 14;
            op.kind = kind_e'(sel[3:0]);
            pick_src(d1, d2, op.rs1);
            pick_src(d1, d2, op.rs2);
            pick_dst(op.rd);
            case (op.kind)
                K_ADDI, K_ANDI, K_ORI, K_SLTI: begin
                    op.imm = word_t'($random(seed) % 64);
                end
                K_LW, K_SW: begin
                    op.rs1 = '0;
                    op.imm = word_t'(({$random(seed)} % 4) * 4);
                end
                K_BEQ, K_BNE, K_JAL: begin
                    skip = {$random(seed)} % 9;
                    if (i + 1 + skip > LOOP_IDX) begin
                        skip = LOOP_IDX - i - 1;   // land on the final loop at most
                    end
                    op.imm = word_t'(4 * (skip + 1));
                    if (op.kind == K_BEQ && ({$random(seed)} % 3 == 0)) begin
                        op.rs2 = op.rs1;           // force some taken beq
                    end
                end
                default: ;
            endcase
            prog[i] = op;
            d2      = d1;
            d1      = writes_reg(op.kind) ? int'(op.rd) : -1;
        end
        op      = '0;
        op.kind = K_JAL;        // jal x0, 0
        prog[LOOP_IDX] = op;
    endtask

    // sequential ISA model, stops at the self loop
    task automatic run_model();
        word_t regs [32];
        word_t dmem [4];
        word_t a;
        word_t b;
        word_t res;
        wb_t   ent;
        op_t   op;
        int    pc;
        int    next;
        foreach (regs[i]) regs[i] = '0;
        foreach (dmem[i]) dmem[i] = '0;
        pc = 0;
        while (pc < LOOP_IDX) begin
            op   = prog[pc];
            a    = regs[op.rs1];
            b    = regs[op.rs2];
            res  = '0;
            next = pc + 1;
            case (op.kind)
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI: res = a + op.imm;
                K_ANDI: res = a & op.imm;
                K_ORI:  res = a | op.imm;
                K_SLTI: res = ($signed(a) < $signed(op.imm)) ? 32'd1 : 32'd0;
                K_LW:   res = dmem[op.imm[3:2]];
                K_SW:   dmem[op.imm[3:2]] = b;
                K_BEQ: begin
                    if (a == b) next = pc + int'($signed(op.imm)) / 4;
                end
                K_BNE: begin
                    if (a != b) next = pc + int'($signed(op.imm)) / 4;
                end
                default: begin
                    res  = word_t'(pc * 4 + 4);
                    next = pc + int'($signed(op.imm)) / 4;
                end
            endcase
            if (writes_reg(op.kind)) begin
                ent.we   = 1'b1;   // x0 writes still raise we
                ent.rd   = op.rd;
                ent.data = res;
                exp_q.push_back(ent);
                if (op.rd != '0) regs[op.rd] = res;
            end
            pc = next;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        logic bad;
        bad = (got.we !== exp.we) || (got.rd !== exp.rd);
        if (exp.rd != '0 && got.data !== exp.data) begin
            bad = 1'b1;   // x0 data is don't care
        end
        if (bad) begin
            abort_run($sformatf(
                "MISMATCH at %0t: writeback %0d got we=%0b x%0d=%h, expected we=%0b x%0d=%h",
                $time, n_seen, got.we, got.rd, got.data, exp.we, exp.rd, exp.data));
        end
    endtask

    task automatic check_idle(input wb_t got);
        if (got.we !== 1'b0) begin
            abort_run($sformatf("MISMATCH at %0t: writeback to x%0d while in reset",
                                $time, got.rd));
        end
    endtask

    // writeback monitor, mid-cycle when wb_o is settled
    always @(negedge clk) begin
        if (!rst_n) begin
            check_idle(wb);
        end else if (wb.we && (n_seen < exp_q.size())) begin
            check_wb(wb, exp_q[n_seen]);
            n_seen <= n_seen + 1;
        end
    end

    initial begin
        int cycles;
        seed      = 32'h6278_0a6a;
        rst_n     = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        build_program();
        run_model();
        // load the image while the core sits in reset
        for (int i = 0; i <= LOOP_IDX; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= word_t'(i * 4);
            imem_data <= encode(prog[i]);
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        cycles = 0;
        while (n_seen < exp_q.size() && cycles < WB_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (n_seen == exp_q.size()) begin
            $display("%0d writebacks matched the reference model", n_seen);
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("timeout waiting for writeback");
        end
    end

endmodule

`default_nettype wire

/* all.f */
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_data_mem.sv
hdl/rv_regfile.sv
hdl/rv_stage_reg.sv
hdl/rv_decode.sv
hdl/rv_fetch.sv
hdl/rv_core.sv
verification/rv_core_asserts.sv
verification/rv_core_tb.sv

/* run_verilator.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
